//--- logic/apb_map_pkg.sv
package apb_map_pkg;

    // -------------------------------------------------------------------------
    // Bus widths
    // -------------------------------------------------------------------------
    localparam int ADDR_W = 9;   // Word address, up to 512 registers
    localparam int DATA_W = 32;
    localparam int GPIO_W = 8;

    // Master side of an APB transfer
    typedef struct packed {
        logic              sel;
        logic              enable;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [3:0]        strb;     // Byte strobes
    } apb_req_t;

    // Slave side
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              ready;
        logic              slverr;
    } apb_rsp_t;

    // -------------------------------------------------------------------------
    // Register map, word addresses
    // -------------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] ADR_ID        = 9'h000;
    localparam logic [ADDR_W-1:0] ADR_REV       = 9'h001;
    localparam logic [ADDR_W-1:0] ADR_GPIO_IN   = 9'h002;
    localparam logic [ADDR_W-1:0] ADR_GPIO_OUT  = 9'h003;
    localparam logic [ADDR_W-1:0] ADR_GPIO_OE   = 9'h004;
    localparam logic [ADDR_W-1:0] ADR_FIFO_DATA = 9'h040;  // Read pops one word
    localparam logic [ADDR_W-1:0] ADR_FIFO_STAT = 9'h041;  // Write clears overflow

    // Fixed read values
    localparam logic [DATA_W-1:0] DEVICE_ID     = 32'hF1F0_7E57;
    localparam logic [15:0]       REV_NUM       = 16'h0100;
    localparam logic [DATA_W-1:0] DEFAULT_RDATA = 32'hFABD_EFAC;  // Unmapped space

endpackage

//--- logic/capture_pkg.sv
package capture_pkg;

    // -------------------------------------------------------------------------
    // Capture path data types
    // -------------------------------------------------------------------------
    typedef logic [7:0]  pixel_t;   // One camera byte
    typedef logic [31:0] word_t;    // Four bytes, first byte in 7:0

    localparam int FIFO_DEPTH = 16;
    localparam int PTR_W      = 4;  // Index into FIFO_DEPTH entries
    localparam int CNT_W      = 5;  // Holds 0 to FIFO_DEPTH

    // Packer output toward the FIFO
    typedef struct packed {
        logic  valid;
        word_t data;
    } cap_word_t;

    // FIFO state as seen by the register block
    typedef struct packed {
        logic [CNT_W-1:0] count;
        logic             empty;
        logic             full;
        logic             overflow;  // Sticky until cleared
    } fifo_status_t;

    // Bytes already held by the packer
    typedef enum logic [1:0] {
        PK_B0 = 2'd0,
        PK_B1 = 2'd1,
        PK_B2 = 2'd2,
        PK_B3 = 2'd3
    } pack_state_t;

endpackage

//--- logic/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer
(
    input  logic                   PCLKI,
    input  logic                   WBs_RST_i,
    input  logic                   vsync_i,
    input  logic                   href_i,
    input  capture_pkg::pixel_t    cam_data_i,
    output capture_pkg::cap_word_t word_o
);

    capture_pkg::pack_state_t state_q;
    capture_pkg::pack_state_t state_d;

    logic                byte_valid;
    logic [23:0]         hold_q;        // Bytes 0 to 2 of the current group
    capture_pkg::word_t  word_data_q;
    logic                word_valid_q;

    assign byte_valid = vsync_i & href_i;

    // Byte counter advance
    always_comb
    begin
        case (state_q)
            capture_pkg::PK_B0: state_d = capture_pkg::PK_B1;
            capture_pkg::PK_B1: state_d = capture_pkg::PK_B2;
            capture_pkg::PK_B2: state_d = capture_pkg::PK_B3;
            default:            state_d = capture_pkg::PK_B0;
        endcase
    end

    // -------------------------------------------------------------------------
    // Control
    // -------------------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            state_q      <= capture_pkg::PK_B0;
            word_valid_q <= 1'b0;
        end
        else
        begin
            if (!vsync_i)
                state_q <= capture_pkg::PK_B0;   // Frame ended, drop partial word
            else if (byte_valid)
                state_q <= state_d;

            // One-cycle strobe after the fourth byte
            word_valid_q <= byte_valid && (state_q == capture_pkg::PK_B3);
        end
    end

    // Byte lanes, filled low to high
    always_ff @(posedge PCLKI)
    begin
        if (byte_valid)
        begin
            case (state_q)
                capture_pkg::PK_B0: hold_q[7:0]   <= cam_data_i;
                capture_pkg::PK_B1: hold_q[15:8]  <= cam_data_i;
                capture_pkg::PK_B2: hold_q[23:16] <= cam_data_i;
                default:            word_data_q   <= {cam_data_i, hold_q};
            endcase
        end
    end

    assign word_o.valid = word_valid_q;
    assign word_o.data  = word_data_q;

endmodule

//--- logic/capture_fifo.sv
`timescale 1ns/1ps

module capture_fifo
(
    input  logic                      PCLKI,
    input  logic                      WBs_RST_i,
    input  capture_pkg::cap_word_t    push_i,
    input  logic                      pop_i,
    input  logic                      clear_ovf_i,
    output capture_pkg::word_t        head_o,
    output capture_pkg::fifo_status_t status_o
);

    capture_pkg::word_t mem [capture_pkg::FIFO_DEPTH];

    logic [capture_pkg::PTR_W-1:0] wr_ptr_q;
    logic [capture_pkg::PTR_W-1:0] rd_ptr_q;
    logic [capture_pkg::CNT_W-1:0] count_q;
    logic                          ovf_q;

    logic empty;
    logic full;
    logic do_push;
    logic do_pop;
    logic drop;

    assign empty = (count_q == '0);
    assign full  = (count_q == capture_pkg::CNT_W'(capture_pkg::FIFO_DEPTH));

    // A full FIFO drops the word even when a pop lands in the same cycle
    assign do_push = push_i.valid & ~full;
    assign drop    = push_i.valid & full;
    assign do_pop  = pop_i & ~empty;       // Pop on empty is ignored

    // -------------------------------------------------------------------------
    // Pointers, count and overflow
    // -------------------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ovf_q    <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;    // Wraps at FIFO_DEPTH
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;

            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // Idle or push with pop
            endcase

            // New drop wins over a clear in the same cycle
            if (drop)
                ovf_q <= 1'b1;
            else if (clear_ovf_i)
                ovf_q <= 1'b0;
        end
    end

    // Storage
    always_ff @(posedge PCLKI)
    begin
        if (do_push)
            mem[wr_ptr_q] <= push_i.data;
    end

    assign head_o = mem[rd_ptr_q];   // Head visible the cycle after a push

    assign status_o.count    = count_q;
    assign status_o.empty    = empty;
    assign status_o.full     = full;
    assign status_o.overflow = ovf_q;

endmodule

//--- logic/apb_reg_block.sv
`timescale 1ns/1ps

module apb_reg_block
(
    input  logic                              PCLKI,
    input  logic                              WBs_RST_i,

    // APB slave
    input  apb_map_pkg::apb_req_t             apb_i,
    output apb_map_pkg::apb_rsp_t             apb_o,

    // GPIO
    input  logic [apb_map_pkg::GPIO_W-1:0]    gpio_in_i,
    output logic [apb_map_pkg::GPIO_W-1:0]    gpio_out_o,
    output logic [apb_map_pkg::GPIO_W-1:0]    gpio_oe_o,

    // Capture FIFO
    input  capture_pkg::word_t                fifo_head_i,
    input  capture_pkg::fifo_status_t         fifo_status_i,
    output logic                              pop_o,
    output logic                              clear_ovf_o
);

    logic access;
    logic wr_access;
    logic rd_access;
    logic gpio_out_wr;
    logic gpio_oe_wr;
    logic fifo_rd;
    logic fifo_empty_rd;

    logic [apb_map_pkg::DATA_W-1:0] stat_word;
    logic [apb_map_pkg::DATA_W-1:0] rdata;

    // -------------------------------------------------------------------------
    // Access-phase decode
    // -------------------------------------------------------------------------
    assign access    = apb_i.sel & apb_i.enable;   // No wait states
    assign wr_access = access & apb_i.write;
    assign rd_access = access & ~apb_i.write;

    assign gpio_out_wr = wr_access && (apb_i.addr == apb_map_pkg::ADR_GPIO_OUT)
                         && apb_i.strb[0];
    assign gpio_oe_wr  = wr_access && (apb_i.addr == apb_map_pkg::ADR_GPIO_OE)
                         && apb_i.strb[0];

    assign fifo_rd       = rd_access && (apb_i.addr == apb_map_pkg::ADR_FIFO_DATA);
    assign fifo_empty_rd = fifo_rd & fifo_status_i.empty;

    assign pop_o       = fifo_rd & ~fifo_status_i.empty;   // Pops at the access edge
    assign clear_ovf_o = wr_access && (apb_i.addr == apb_map_pkg::ADR_FIFO_STAT);

    // GPIO output and enable registers
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            gpio_out_o <= '0;
            gpio_oe_o  <= '0;
        end
        else
        begin
            if (gpio_out_wr)
                gpio_out_o <= apb_i.wdata[apb_map_pkg::GPIO_W-1:0];
            if (gpio_oe_wr)
                gpio_oe_o  <= apb_i.wdata[apb_map_pkg::GPIO_W-1:0];
        end
    end

    // -------------------------------------------------------------------------
    // Read mux
    // -------------------------------------------------------------------------

    // Overflow at bit 16, full and empty at 9 and 8, count in the low bits
    assign stat_word = {15'h0,
                        fifo_status_i.overflow,
                        6'h0,
                        fifo_status_i.full,
                        fifo_status_i.empty,
                        3'h0,
                        fifo_status_i.count};

    always_comb
    begin
        case (apb_i.addr)
            apb_map_pkg::ADR_ID:        rdata = apb_map_pkg::DEVICE_ID;
            apb_map_pkg::ADR_REV:       rdata = {16'h0, apb_map_pkg::REV_NUM};
            apb_map_pkg::ADR_GPIO_IN:   rdata = {24'h0, gpio_in_i};
            apb_map_pkg::ADR_GPIO_OUT:  rdata = {24'h0, gpio_out_o};
            apb_map_pkg::ADR_GPIO_OE:   rdata = {24'h0, gpio_oe_o};
            apb_map_pkg::ADR_FIFO_DATA:
            begin
                if (fifo_status_i.empty)
                    rdata = apb_map_pkg::DEFAULT_RDATA;   // Nothing to pop
                else
                    rdata = fifo_head_i;
            end
            apb_map_pkg::ADR_FIFO_STAT: rdata = stat_word;
            default:                    rdata = apb_map_pkg::DEFAULT_RDATA;
        endcase
    end

    assign apb_o.rdata  = rdata;
    assign apb_o.ready  = access;
    assign apb_o.slverr = fifo_empty_rd;   // Read of an empty FIFO

endmodule

//--- logic/camera_bridge_top.sv
`timescale 1ns/1ps

module camera_bridge_top
(
    input  logic                           PCLKI,
    input  logic                           WBs_RST_i,

    // APB slave
    input  apb_map_pkg::apb_req_t          apb_i,
    output apb_map_pkg::apb_rsp_t          apb_o,

    // Camera
    input  logic                           vsync_i,
    input  logic                           href_i,
    input  capture_pkg::pixel_t            cam_data_i,

    // GPIO
    input  logic [apb_map_pkg::GPIO_W-1:0] gpio_in_i,
    output logic [apb_map_pkg::GPIO_W-1:0] gpio_out_o,
    output logic [apb_map_pkg::GPIO_W-1:0] gpio_oe_o
);

    capture_pkg::cap_word_t    packed_word;
    capture_pkg::word_t        fifo_head;
    capture_pkg::fifo_status_t fifo_status;
    logic                      fifo_pop;
    logic                      fifo_clear_ovf;

    // -------------------------------------------------------------------------
    // Capture path
    // -------------------------------------------------------------------------
    pixel_packer pixel_packer_inst
    (
        .PCLKI       (PCLKI),
        .WBs_RST_i   (WBs_RST_i),
        .vsync_i     (vsync_i),
        .href_i      (href_i),
        .cam_data_i  (cam_data_i),
        .word_o      (packed_word)
    );

    capture_fifo capture_fifo_inst
    (
        .PCLKI       (PCLKI),
        .WBs_RST_i   (WBs_RST_i),
        .push_i      (packed_word),
        .pop_i       (fifo_pop),
        .clear_ovf_i (fifo_clear_ovf),
        .head_o      (fifo_head),
        .status_o    (fifo_status)
    );

    // Register access
    apb_reg_block apb_reg_block_inst
    (
        .PCLKI         (PCLKI),
        .WBs_RST_i     (WBs_RST_i),
        .apb_i         (apb_i),
        .apb_o         (apb_o),
        .gpio_in_i     (gpio_in_i),
        .gpio_out_o    (gpio_out_o),
        .gpio_oe_o     (gpio_oe_o),
        .fifo_head_i   (fifo_head),
        .fifo_status_i (fifo_status),
        .pop_o         (fifo_pop),
        .clear_ovf_o   (fifo_clear_ovf)
    );

endmodule

//--- test/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

    // -----------------------------------------------------------------------
    // Stimulus and reference model
    // -----------------------------------------------------------------------

    // Galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        else
            return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);   // One step per bit
        end
        return v;
    endfunction

    // First byte of a group lands in the low lane
    function automatic capture_pkg::word_t pack_ref(input capture_pkg::pixel_t b0,
        input capture_pkg::pixel_t b1, input capture_pkg::pixel_t b2,
        input capture_pkg::pixel_t b3);
        return {b3, b2, b1, b0};
    endfunction

    // Status register layout
    function automatic capture_pkg::fifo_status_t decode_status(input logic [31:0] w);
        capture_pkg::fifo_status_t s;
        s.count    = w[4:0];
        s.empty    = w[8];
        s.full     = w[9];
        s.overflow = w[16];
        return s;
    endfunction

    // -----------------------------------------------------------------------
    // APB master, entered and left on a falling edge
    // -----------------------------------------------------------------------
    task automatic apb_transfer(input logic wr, input logic [apb_map_pkg::ADDR_W-1:0] addr,
        input logic [31:0] wdata, input logic [3:0] strb,
        output logic [31:0] rdata, output logic slverr);
        apb_req.sel    = 1'b1;
        apb_req.enable = 1'b0;                  // Setup cycle
        apb_req.write  = wr;
        apb_req.addr   = addr;
        apb_req.wdata  = wdata;
        apb_req.strb   = strb;
        #(SAMPLE_DELAY);
        if (apb_rsp.ready !== 1'b0)
            stop_on_error("APB ready was high during a setup cycle");
        @(negedge PCLKI);
        apb_req.enable = 1'b1;
        #(SAMPLE_DELAY);
        if (apb_rsp.ready !== 1'b1)
            stop_on_error("APB ready was low during an access cycle");
        rdata  = apb_rsp.rdata;
        slverr = apb_rsp.slverr;
        @(negedge PCLKI);
        apb_req = '0;   // Idle unless another transfer follows at once
    endtask

    // Compare tasks
    task automatic check_word(input string name, input capture_pkg::word_t got,
        input capture_pkg::word_t exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: %s got %08h expected %08h",
                                    $time, name, got, exp));
    endtask

    task automatic check_status(input string name, input capture_pkg::fifo_status_t got,
        input capture_pkg::fifo_status_t exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: %s got %p expected %p",
                                    $time, name, got, exp));
    endtask

    task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: %s got %02h expected %02h",
                                    $time, name, got, exp));
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: %s got %0b expected %0b",
                                    $time, name, got, exp));
    endtask

`endif

//--- test/camera_bridge_tb.sv
`timescale 1ns/1ps

module camera_bridge_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int SAMPLE_DELAY = 2;       // Sample point after inputs settle
    localparam int BURSTS       = 3;
    localparam int BURST_WORDS  = 4;
    localparam int FILL_WORDS   = 20;      // Four more than the FIFO holds
    localparam logic [15:0] LFSR_SEED = 16'd39238;

    // Watchdog budget with gap cycles counted as pixels
    localparam int N_XFERS  = 4 + 9 + BURSTS * (BURST_WORDS + 1) + 2
                              + (capture_pkg::FIFO_DEPTH + 4) + 2;
    localparam int N_PIXELS = BURSTS * BURST_WORDS * 8 + 7 + FILL_WORDS * 4;
    localparam int WATCHDOG_CYCLES = N_XFERS * 2 + N_PIXELS + 100;

    typedef logic [apb_map_pkg::GPIO_W-1:0] gpio_t;

    logic                  PCLKI;
    logic                  WBs_RST_i;
    apb_map_pkg::apb_req_t apb_req;
    apb_map_pkg::apb_rsp_t apb_rsp;
    logic                  vsync;
    logic                  href;
    capture_pkg::pixel_t   cam_data;
    gpio_t                 gpio_in;
    gpio_t                 gpio_out;
    gpio_t                 gpio_oe;

    capture_pkg::word_t sb_q [$];          // Words expected in the FIFO in arrival order
    logic               exp_ovf       = 1'b0;
    logic [15:0]        lfsr_state    = LFSR_SEED;
    capture_pkg::word_t mon_data;
    logic               mon_err;
    event               fifo_read_ev;
    logic [31:0]        rdata;
    logic               err;
    gpio_t              exp_out;
    gpio_t              exp_oe;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    `include "tb_checks.svh"

    camera_bridge_top camera_bridge_top_inst
    (
        .PCLKI      (PCLKI),
        .WBs_RST_i  (WBs_RST_i),
        .apb_i      (apb_req),
        .apb_o      (apb_rsp),
        .vsync_i    (vsync),
        .href_i     (href),
        .cam_data_i (cam_data),
        .gpio_in_i  (gpio_in),
        .gpio_out_o (gpio_out),
        .gpio_oe_o  (gpio_oe)
    );

    initial
    begin
        PCLKI = 1'b0;
        forever #(CLK_PERIOD / 2) PCLKI = ~PCLKI;
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge PCLKI);
        stop_on_error($sformatf("Timeout: run did not end within %0d cycles", WATCHDOG_CYCLES));
    end

    // Scoreboard compare for every FIFO data read
    initial
    begin : compare_reads
        capture_pkg::word_t exp_word;
        forever
        begin
            @(fifo_read_ev);
            if (sb_q.size() == 0)
            begin
                check_word("FIFO data on empty", mon_data, apb_map_pkg::DEFAULT_RDATA);
                check_err("slverr on empty", mon_err, 1'b1);
            end
            else
            begin
                exp_word = sb_q.pop_front();
                check_word("FIFO data", mon_data, exp_word);
                check_err("FIFO data slverr", mon_err, 1'b0);
            end
        end
    end

    // -----------------------------------------------------------------------
    // Camera and FIFO helpers
    // -----------------------------------------------------------------------
    task automatic cam_cycle(input logic vs, input logic hr, input capture_pkg::pixel_t d);
        vsync    = vs;
        href     = hr;
        cam_data = d;
        @(negedge PCLKI);
    endtask

    task automatic send_word(input logic with_gaps);
        capture_pkg::pixel_t b [4];
        int                  i;
        for (i = 0; i < 4; i++)
        begin
            if (with_gaps && rand_bits(2) == 32'd0)
                cam_cycle(1'b1, 1'b0, capture_pkg::pixel_t'(rand_bits(8)));  // Line gap
            b[i] = capture_pkg::pixel_t'(rand_bits(8));
            cam_cycle(1'b1, 1'b1, b[i]);
        end
        if (sb_q.size() < capture_pkg::FIFO_DEPTH)
            sb_q.push_back(pack_ref(b[0], b[1], b[2], b[3]));
        else
            exp_ovf = 1'b1;                    // Dropped by a full FIFO
    endtask

    // Frame end and time for the last word to reach the FIFO
    task automatic end_frame();
        cam_cycle(1'b0, 1'b0, '0);
        repeat (2) @(negedge PCLKI);
    endtask

    task automatic fifo_read();
        logic [31:0] data;
        logic        slverr;
        apb_transfer(1'b0, apb_map_pkg::ADR_FIFO_DATA, '0, '0, data, slverr);
        mon_data = data;
        mon_err  = slverr;
        -> fifo_read_ev;
    endtask

    task automatic check_fifo_status();
        logic [31:0]               data;
        logic                      slverr;
        capture_pkg::fifo_status_t exp_st;
        apb_transfer(1'b0, apb_map_pkg::ADR_FIFO_STAT, '0, '0, data, slverr);
        exp_st.count    = capture_pkg::CNT_W'(sb_q.size());
        exp_st.empty    = (sb_q.size() == 0);
        exp_st.full     = (sb_q.size() == capture_pkg::FIFO_DEPTH);
        exp_st.overflow = exp_ovf;
        check_status("FIFO status", decode_status(data), exp_st);
        check_err("status slverr", slverr, 1'b0);
    endtask

    // -----------------------------------------------------------------------
    // Test sequence
    // -----------------------------------------------------------------------
    initial
    begin
        WBs_RST_i = 1'b1;
        apb_req   = '0;
        vsync     = 1'b0;
        href      = 1'b0;
        cam_data  = '0;
        gpio_in   = '0;
        repeat (10) @(negedge PCLKI);
        WBs_RST_i = 1'b0;
        @(negedge PCLKI);

        // Reset values, ID and unmapped space
        check_gpio("gpio_out_o", gpio_out, '0);
        check_gpio("gpio_oe_o", gpio_oe, '0);
        apb_transfer(1'b0, apb_map_pkg::ADR_ID, '0, '0, rdata, err);
        check_word("ID", rdata, apb_map_pkg::DEVICE_ID);
        apb_transfer(1'b0, apb_map_pkg::ADR_REV, '0, '0, rdata, err);
        check_word("REV", rdata, {16'h0, apb_map_pkg::REV_NUM});
        check_fifo_status();
        apb_transfer(1'b0, 9'h1A5, '0, '0, rdata, err);
        check_word("unmapped read", rdata, apb_map_pkg::DEFAULT_RDATA);
        check_err("unmapped slverr", err, 1'b0);

        // GPIO writes gated by the lane 0 strobe
        gpio_in = gpio_t'(rand_bits(apb_map_pkg::GPIO_W));
        apb_transfer(1'b0, apb_map_pkg::ADR_GPIO_IN, '0, '0, rdata, err);
        check_gpio("GPIO_IN", gpio_t'(rdata), gpio_in);
        exp_out = gpio_t'(rand_bits(apb_map_pkg::GPIO_W));
        apb_transfer(1'b1, apb_map_pkg::ADR_GPIO_OUT, {24'h5A5A5A, exp_out}, 4'b0001, rdata, err);
        check_gpio("gpio_out_o", gpio_out, exp_out);
        apb_transfer(1'b1, apb_map_pkg::ADR_GPIO_OUT, {24'h0, ~exp_out}, 4'b1110, rdata, err);
        check_gpio("gpio_out_o", gpio_out, exp_out);
        apb_transfer(1'b0, apb_map_pkg::ADR_GPIO_OUT, '0, '0, rdata, err);
        check_gpio("GPIO_OUT", gpio_t'(rdata), exp_out);
        exp_oe = gpio_t'(rand_bits(apb_map_pkg::GPIO_W));
        apb_transfer(1'b1, apb_map_pkg::ADR_GPIO_OE, {24'h0, exp_oe}, 4'b1111, rdata, err);
        apb_transfer(1'b1, apb_map_pkg::ADR_GPIO_OE, {24'h0, ~exp_oe}, 4'b0000, rdata, err);
        check_gpio("gpio_oe_o", gpio_oe, exp_oe);
        apb_transfer(1'b0, apb_map_pkg::ADR_GPIO_OE, '0, '0, rdata, err);
        check_gpio("GPIO_OE", gpio_t'(rdata), exp_oe);
        apb_transfer(1'b1, apb_map_pkg::ADR_ID, 32'h0, 4'hF, rdata, err);  // Read-only
        apb_transfer(1'b0, apb_map_pkg::ADR_ID, '0, '0, rdata, err);
        check_word("ID after write", rdata, apb_map_pkg::DEVICE_ID);

        // Random bursts with line gaps
        repeat (BURSTS)
        begin
            repeat (BURST_WORDS) send_word(1'b1);
            end_frame();
            check_fifo_status();
            repeat (BURST_WORDS) fifo_read();
        end

        // Two bytes cut off by vsync while href stays high
        cam_cycle(1'b1, 1'b1, capture_pkg::pixel_t'(rand_bits(8)));
        cam_cycle(1'b1, 1'b1, capture_pkg::pixel_t'(rand_bits(8)));
        cam_cycle(1'b0, 1'b1, capture_pkg::pixel_t'(rand_bits(8)));
        send_word(1'b0);
        end_frame();
        check_fifo_status();
        fifo_read();

        // Overrun with no reads before the drain and clear
        repeat (FILL_WORDS) send_word(1'b0);
        end_frame();
        check_fifo_status();
        repeat (capture_pkg::FIFO_DEPTH) fifo_read();
        check_fifo_status();
        apb_transfer(1'b1, apb_map_pkg::ADR_FIFO_STAT, '0, 4'hF, rdata, err);
        exp_ovf = 1'b0;
        check_fifo_status();

        // Read of an empty FIFO
        fifo_read();
        check_fifo_status();

        @(negedge PCLKI);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+test
logic/apb_map_pkg.sv
logic/capture_pkg.sv
logic/pixel_packer.sv
logic/capture_fifo.sv
logic/apb_reg_block.sv
logic/camera_bridge_top.sv
test/camera_bridge_tb.sv

//--- Bender.yml
package:
  name: camera_bridge

sources:
  # Packages first, then the design from the leaves up
  - logic/apb_map_pkg.sv
  - logic/capture_pkg.sv
  - logic/pixel_packer.sv
  - logic/capture_fifo.sv
  - logic/apb_reg_block.sv
  - logic/camera_bridge_top.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/camera_bridge_tb.sv
